/* logic/mmc1_defines.svh */
`ifndef MMC1_DEFINES_SVH
`define MMC1_DEFINES_SVH

// ******************************
// Address widths
// ******************************

// CHR high bit, 4-bit bank and 14-bit offset.
`define MMC1_PRG_ADDR_BITS 19
// 5-bit bank and 12-bit offset.
`define MMC1_CHR_ADDR_BITS 17

// ******************************
// Reset values
// ******************************

// Only the marker bit is set so that five writes fill the register.
`define MMC1_SHIFT_EMPTY 5'b10000
// PRG fix last, CHR 8K, one-screen low.
`define MMC1_CTRL_RESET 5'b01100

// ******************************
// Save-state slots
// ******************************

`define MMC1_SST_SHIFT 3'd0
`define MMC1_SST_CTRL 3'd1
`define MMC1_SST_CHR0 3'd2
`define MMC1_SST_CHR1 3'd3
`define MMC1_SST_PRG 3'd4
`define MMC1_SST_NONE 8'hFF

`endif

/* logic/mmc1_pkg.sv */
package mmc1_pkg;

    // CIRAM A10 source.
    typedef enum logic [1:0] {
        MIR_ONE_LOW    = 2'd0,
        MIR_ONE_HIGH   = 2'd1,
        MIR_VERTICAL   = 2'd2,
        MIR_HORIZONTAL = 2'd3
    } mirroring_e;

    // Modes 0 and 1 both map a 32K window.
    typedef enum logic [1:0] {
        PRG_32K_A     = 2'd0,
        PRG_32K_B     = 2'd1,
        PRG_FIX_FIRST = 2'd2,
        PRG_FIX_LAST  = 2'd3
    } prg_mode_e;

    // Control register layout with the MSB first.
    typedef struct packed {
        logic       chr_mode;
        prg_mode_e  prg_mode;
        mirroring_e mirroring;
    } ctrl_t;

    // A committed word is either a control value or a bank number.
    typedef union packed {
        ctrl_t      ctrl;
        logic [4:0] bank;
    } reg_word_u;

    // Commit target from CPU address bits 14 and 13.
    typedef enum logic [1:0] {
        SEL_CTRL = 2'd0,
        SEL_CHR0 = 2'd1,
        SEL_CHR1 = 2'd2,
        SEL_PRG  = 2'd3
    } reg_sel_e;

    typedef logic [7:0] sst_byte_t;

endpackage

/* logic/mmc1_serial_loader.sv */
`timescale 1ns/1ps
`include "mmc1_defines.svh"

module mmc1_serial_loader (
    input  logic                m2,
    input  logic                rst,
    input  logic [15:0]         cpu_addr,
    input  logic                cpu_rw,
    input  logic [7:0]          cpu_data_in,
    input  logic                sst_enable,
    input  logic                sst_we,
    input  logic [2:0]          sst_addr,
    input  mmc1_pkg::sst_byte_t sst_data_in,
    output logic                commit,
    output mmc1_pkg::reg_sel_e  commit_sel,
    output mmc1_pkg::reg_word_u commit_word,
    output logic                clear,
    output logic [4:0]          shift_value
);

    logic [4:0] shift;
    logic [4:0] shift_next;
    logic       serial_we;

    // Any CPU write to $8000-$FFFF, unless save-state owns the port.
    assign serial_we = !sst_enable && cpu_addr[15] && !cpu_rw;

    // New bit enters at the top; marker bit walks down.
    assign shift_next = {cpu_data_in[0], shift[4:1]};

    // ******************************
    // Commit and clear
    // ******************************

    assign clear = serial_we && cpu_data_in[7];

    // Marker in bit 0 means this is the fifth write.
    assign commit = serial_we && !cpu_data_in[7] && shift[0];

    assign commit_sel = mmc1_pkg::reg_sel_e'(cpu_addr[14:13]);
    assign commit_word.bank = shift_next;
    assign shift_value = shift;

    always_ff @(posedge m2) begin
        if (rst) begin
            shift <= `MMC1_SHIFT_EMPTY;
        end else if (sst_enable) begin
            if (sst_we && sst_addr == `MMC1_SST_SHIFT) begin
                shift <= sst_data_in[4:0];
            end
        end else if (clear || commit) begin
            shift <= `MMC1_SHIFT_EMPTY;
        end else if (serial_we) begin
            shift <= shift_next;
        end
    end

endmodule

/* logic/mmc1_bank_regs.sv */
`timescale 1ns/1ps
`include "mmc1_defines.svh"

module mmc1_bank_regs (
    input  logic                m2,
    input  logic                rst,
    input  logic                commit,
    input  logic [1:0]          commit_sel,
    input  mmc1_pkg::reg_word_u commit_word,
    input  logic                clear,
    input  logic [4:0]          shift_value,
    input  logic                sst_enable,
    input  logic                sst_we,
    input  logic [2:0]          sst_addr,
    input  mmc1_pkg::sst_byte_t sst_data_in,
    output mmc1_pkg::sst_byte_t sst_data_out,
    output mmc1_pkg::ctrl_t     ctrl,
    output logic [4:0]          chr_bank_0,
    output logic [4:0]          chr_bank_1,
    output logic [3:0]          prg_bank
);

    mmc1_pkg::reg_sel_e target;

    assign target = mmc1_pkg::reg_sel_e'(commit_sel);

    // ******************************
    // Register update
    // ******************************

    always_ff @(posedge m2) begin
        if (rst) begin
            ctrl       <= mmc1_pkg::ctrl_t'(`MMC1_CTRL_RESET);
            chr_bank_0 <= '0;
            chr_bank_1 <= '0;
            prg_bank   <= '0;
        end else if (sst_enable) begin
            if (sst_we) begin
                case (sst_addr)
                    `MMC1_SST_CTRL: ctrl <= mmc1_pkg::ctrl_t'(sst_data_in[4:0]);
                    `MMC1_SST_CHR0: chr_bank_0 <= sst_data_in[4:0];
                    `MMC1_SST_CHR1: chr_bank_1 <= sst_data_in[4:0];
                    `MMC1_SST_PRG:  prg_bank <= sst_data_in[3:0];
                    default: ;
                endcase
            end
        end else if (clear) begin
            // Bit 7 write keeps mirroring and CHR mode.
            ctrl.prg_mode <= mmc1_pkg::PRG_FIX_LAST;
        end else if (commit) begin
            case (target)
                mmc1_pkg::SEL_CTRL: ctrl <= commit_word.ctrl;
                mmc1_pkg::SEL_CHR0: chr_bank_0 <= commit_word.bank;
                mmc1_pkg::SEL_CHR1: chr_bank_1 <= commit_word.bank;
                mmc1_pkg::SEL_PRG:  prg_bank <= commit_word.bank[3:0];
                default: ;
            endcase
        end
    end

    // ******************************
    // Save-state readback
    // ******************************

    always_comb begin
        case (sst_addr)
            `MMC1_SST_SHIFT: sst_data_out = {3'b000, shift_value};
            `MMC1_SST_CTRL:  sst_data_out = {3'b000, ctrl};
            `MMC1_SST_CHR0:  sst_data_out = {3'b000, chr_bank_0};
            `MMC1_SST_CHR1:  sst_data_out = {3'b000, chr_bank_1};
            `MMC1_SST_PRG:   sst_data_out = {4'b0000, prg_bank};
            default:         sst_data_out = `MMC1_SST_NONE;
        endcase
    end

endmodule

/* logic/mmc1_prg_window.sv */
`timescale 1ns/1ps
`include "mmc1_defines.svh"

module mmc1_prg_window (
    input  logic [15:0]                    cpu_addr,
    input  logic                           cpu_rw,
    input  mmc1_pkg::ctrl_t                ctrl,
    input  logic [3:0]                     prg_bank,
    input  logic                           chr_high,
    output logic [`MMC1_PRG_ADDR_BITS-1:0] prg_addr,
    output logic                           prg_oe,
    output logic                           prg_we,
    output logic                           wram_ce
);

    logic [3:0] prg_sel;

    // Work RAM at $6000-$7FFF.
    assign wram_ce = cpu_addr[15:13] == 3'b011;

    // ******************************
    // 16K bank select
    // ******************************

    always_comb begin
        case (ctrl.prg_mode)
            mmc1_pkg::PRG_FIX_FIRST: prg_sel = cpu_addr[14] ? prg_bank : 4'h0;
            mmc1_pkg::PRG_FIX_LAST:  prg_sel = cpu_addr[14] ? 4'hF : prg_bank;
            // 32K modes ignore the low bank bit.
            default:                 prg_sel = {prg_bank[3:1], cpu_addr[14]};
        endcase
    end

    always_comb begin
        if (wram_ce) begin
            prg_addr = {{(`MMC1_PRG_ADDR_BITS - 13){1'b0}}, cpu_addr[12:0]};
        end else begin
            prg_addr = {chr_high, prg_sel, cpu_addr[13:0]};
        end
    end

    // ROM is read-only, so only WRAM gets a write strobe.
    assign prg_oe = cpu_rw && (cpu_addr[15] || wram_ce);
    assign prg_we = !cpu_rw && wram_ce;

endmodule

/* logic/mmc1_chr_window.sv */
`timescale 1ns/1ps
`include "mmc1_defines.svh"

module mmc1_chr_window (
    input  logic [13:0]                    ppu_addr,
    input  logic                           ppu_rd,
    input  logic                           ppu_wr,
    input  logic                           chr_ram,
    input  mmc1_pkg::ctrl_t                ctrl,
    input  logic [4:0]                     chr_bank_0,
    input  logic [4:0]                     chr_bank_1,
    output logic [`MMC1_CHR_ADDR_BITS-1:0] chr_addr,
    output logic                           chr_ce,
    output logic                           chr_oe,
    output logic                           chr_we,
    output logic                           ciram_ce,
    output logic                           ciram_a10
);

    logic [4:0] chr_sel;

    // ******************************
    // 4K bank select
    // ******************************

    always_comb begin
        if (!ctrl.chr_mode) begin
            // In 8K mode bank 0 picks an even/odd pair.
            chr_sel = {chr_bank_0[4:1], ppu_addr[12]};
        end else begin
            chr_sel = ppu_addr[12] ? chr_bank_1 : chr_bank_0;
        end
    end

    assign chr_addr = {chr_ram ? {4'b0000, ppu_addr[12]} : chr_sel, ppu_addr[11:0]};

    // Pattern tables below $2000, nametables above.
    assign ciram_ce = !ppu_addr[13];
    assign chr_ce   = ciram_ce;
    assign chr_oe   = !ppu_rd;
    assign chr_we   = chr_ram && !ppu_wr;

    always_comb begin
        case (ctrl.mirroring)
            mmc1_pkg::MIR_ONE_LOW:  ciram_a10 = 1'b0;
            mmc1_pkg::MIR_ONE_HIGH: ciram_a10 = 1'b1;
            mmc1_pkg::MIR_VERTICAL: ciram_a10 = ppu_addr[10];
            default:                ciram_a10 = ppu_addr[11];
        endcase
    end

endmodule

/* logic/mmc1_mapper.sv */
`timescale 1ns/1ps
`include "mmc1_defines.svh"

module mmc1_mapper (
    input  logic                           m2,
    input  logic                           rst,
    // CPU bus
    input  logic [15:0]                    cpu_addr,
    input  logic                           cpu_rw,
    input  logic [7:0]                     cpu_data_in,
    output logic [`MMC1_PRG_ADDR_BITS-1:0] prg_addr,
    output logic                           prg_oe,
    output logic                           prg_we,
    output logic                           wram_ce,
    // PPU bus
    input  logic [13:0]                    ppu_addr,
    input  logic                           ppu_rd,
    input  logic                           ppu_wr,
    input  logic                           chr_ram,
    output logic [`MMC1_CHR_ADDR_BITS-1:0] chr_addr,
    output logic                           chr_ce,
    output logic                           chr_oe,
    output logic                           chr_we,
    output logic                           ciram_ce,
    output logic                           ciram_a10,
    // Save-state port
    input  logic                           sst_enable,
    input  logic                           sst_we,
    input  logic [2:0]                     sst_addr,
    input  logic [7:0]                     sst_data_in,
    output logic [7:0]                     sst_data_out
);

    logic       commit;
    logic [1:0] commit_sel;
    logic [4:0] commit_word;
    logic       clear;
    logic [4:0] shift_value;
    logic [4:0] ctrl;
    logic [4:0] chr_bank_0;
    logic [4:0] chr_bank_1;
    logic [3:0] prg_bank;

    // ******************************
    // Serial port and registers
    // ******************************

    mmc1_serial_loader u_loader (
        .m2          (m2),
        .rst         (rst),
        .cpu_addr    (cpu_addr),
        .cpu_rw      (cpu_rw),
        .cpu_data_in (cpu_data_in),
        .sst_enable  (sst_enable),
        .sst_we      (sst_we),
        .sst_addr    (sst_addr),
        .sst_data_in (sst_data_in),
        .commit      (commit),
        .commit_sel  (commit_sel),
        .commit_word (commit_word),
        .clear       (clear),
        .shift_value (shift_value)
    );

    mmc1_bank_regs u_regs (
        .m2           (m2),
        .rst          (rst),
        .commit       (commit),
        .commit_sel   (commit_sel),
        .commit_word  (commit_word),
        .clear        (clear),
        .shift_value  (shift_value),
        .sst_enable   (sst_enable),
        .sst_we       (sst_we),
        .sst_addr     (sst_addr),
        .sst_data_in  (sst_data_in),
        .sst_data_out (sst_data_out),
        .ctrl         (ctrl),
        .chr_bank_0   (chr_bank_0),
        .chr_bank_1   (chr_bank_1),
        .prg_bank     (prg_bank)
    );

    // ******************************
    // Address windows
    // ******************************

    // CHR bank 0 bit 4 doubles as the 256K PRG select.
    mmc1_prg_window u_prg (
        .cpu_addr (cpu_addr),
        .cpu_rw   (cpu_rw),
        .ctrl     (ctrl),
        .prg_bank (prg_bank),
        .chr_high (chr_bank_0[4]),
        .prg_addr (prg_addr),
        .prg_oe   (prg_oe),
        .prg_we   (prg_we),
        .wram_ce  (wram_ce)
    );

    mmc1_chr_window u_chr (
        .ppu_addr   (ppu_addr),
        .ppu_rd     (ppu_rd),
        .ppu_wr     (ppu_wr),
        .chr_ram    (chr_ram),
        .ctrl       (ctrl),
        .chr_bank_0 (chr_bank_0),
        .chr_bank_1 (chr_bank_1),
        .chr_addr   (chr_addr),
        .chr_ce     (chr_ce),
        .chr_oe     (chr_oe),
        .chr_we     (chr_we),
        .ciram_ce   (ciram_ce),
        .ciram_a10  (ciram_a10)
    );

endmodule

/* tests/mmc1_mapper_tb.sv */
`timescale 1ns/1ps
`include "mmc1_defines.svh"

module mmc1_mapper_tb;

    logic                           m2;
    logic                           rst;
    logic [15:0]                    cpu_addr;
    logic                           cpu_rw;
    logic [7:0]                     cpu_data_in;
    logic [`MMC1_PRG_ADDR_BITS-1:0] prg_addr;
    logic                           prg_oe;
    logic                           prg_we;
    logic                           wram_ce;
    logic [13:0]                    ppu_addr;
    logic                           ppu_rd;
    logic                           ppu_wr;
    logic                           chr_ram;
    logic [`MMC1_CHR_ADDR_BITS-1:0] chr_addr;
    logic                           chr_ce;
    logic                           chr_oe;
    logic                           chr_we;
    logic                           ciram_ce;
    logic                           ciram_a10;
    logic                           sst_enable;
    logic                           sst_we;
    logic [2:0]                     sst_addr;
    mmc1_pkg::sst_byte_t            sst_data_in;
    mmc1_pkg::sst_byte_t            sst_data_out;

    string       names[$];
    string       ops[$];
    logic [15:0] f0s[$];
    logic [15:0] f1s[$];
    logic [15:0] f2s[$];
    logic [15:0] f3s[$];
    logic [31:0] lfsr;
    int          cycles;
    int          limit;

    mmc1_mapper u_dut (
        .m2 (m2), .rst (rst),
        .cpu_addr (cpu_addr), .cpu_rw (cpu_rw), .cpu_data_in (cpu_data_in),
        .prg_addr (prg_addr), .prg_oe (prg_oe), .prg_we (prg_we), .wram_ce (wram_ce),
        .ppu_addr (ppu_addr), .ppu_rd (ppu_rd), .ppu_wr (ppu_wr), .chr_ram (chr_ram),
        .chr_addr (chr_addr), .chr_ce (chr_ce), .chr_oe (chr_oe), .chr_we (chr_we),
        .ciram_ce (ciram_ce), .ciram_a10 (ciram_a10),
        .sst_enable (sst_enable), .sst_we (sst_we), .sst_addr (sst_addr),
        .sst_data_in (sst_data_in), .sst_data_out (sst_data_out)
    );

    initial begin
        m2 = 1'b0;
        forever #10 m2 = ~m2;
    end

    always @(posedge m2) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run passed the limit of %0d cycles", limit);
            abort_run();
        end
    end

    // ******************************
    // Helpers
    // ******************************

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_prg_addr(input string name, input logic [`MMC1_PRG_ADDR_BITS-1:0] exp,
                                  input logic [`MMC1_PRG_ADDR_BITS-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_chr_addr(input string name, input logic [`MMC1_CHR_ADDR_BITS-1:0] exp,
                                  input logic [`MMC1_CHR_ADDR_BITS-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_sst(input string name, input mmc1_pkg::sst_byte_t exp,
                             input mmc1_pkg::sst_byte_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_strobe(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // ******************************
    // Bus operations
    // ******************************

    // Quiet values that later assignments of the caller override.
    task automatic idle_bus();
        cpu_addr    <= 16'h0000;
        cpu_rw      <= 1'b1;
        cpu_data_in <= 8'h00;
        ppu_rd      <= 1'b1;
        ppu_wr      <= 1'b1;
        chr_ram     <= 1'b0;
        sst_enable  <= 1'b0;
        sst_we      <= 1'b0;
        sst_data_in <= 8'h00;
    endtask

    // Write i carries bit i of data in bit 0, and data bit 7 as is.
    task automatic serial_write(input logic [15:0] addr, input logic [15:0] data,
                                input logic [15:0] count, input logic sst_en);
        int n;
        n = int'(count);
        for (int i = 0; i < n; i++) begin
            @(posedge m2);
            idle_bus();
            cpu_addr    <= addr;
            cpu_rw      <= 1'b0;
            cpu_data_in <= {data[7], 6'b000000, data[i]};
            sst_enable  <= sst_en;
        end
    endtask

    task automatic cpu_probe(input string name, input logic [15:0] base, input logic rw,
                             input logic [4:0] bank);
        logic [15:0]                    rnd;
        logic [15:0]                    addr;
        logic                           wram;
        logic [`MMC1_PRG_ADDR_BITS-1:0] exp_addr;
        wram = base[15:13] == 3'b011;
        if (wram) begin
            draw_bits(13, rnd);
            addr = {base[15:13], rnd[12:0]};
            exp_addr = {6'b000000, addr[12:0]};
        end else begin
            draw_bits(14, rnd);
            addr = {base[15:14], rnd[13:0]};
            exp_addr = {bank, addr[13:0]};
        end
        @(posedge m2);
        idle_bus();
        cpu_addr <= addr;
        cpu_rw   <= rw;
        @(negedge m2);
        check_prg_addr({name, "/prg_addr"}, exp_addr, prg_addr);
        check_strobe({name, "/prg_oe"}, rw && (addr[15] || wram), prg_oe);
        check_strobe({name, "/prg_we"}, !rw && wram, prg_we);
        check_strobe({name, "/wram_ce"}, wram, wram_ce);
    endtask

    // Flags bit 0 is chr_ram, bit 1 makes the probe a write.
    task automatic ppu_probe(input string name, input logic [15:0] base,
                             input logic [15:0] flags, input logic [4:0] bank,
                             input logic [1:0] mir);
        logic [15:0] rnd;
        logic [13:0] addr;
        logic        exp_a10;
        draw_bits(12, rnd);
        addr = {base[13:12], rnd[11:0]};
        case (mir)
            2'd0:    exp_a10 = 1'b0;
            2'd1:    exp_a10 = 1'b1;
            2'd2:    exp_a10 = addr[10];
            default: exp_a10 = addr[11];
        endcase
        @(posedge m2);
        idle_bus();
        ppu_addr <= addr;
        ppu_rd   <= flags[1];
        ppu_wr   <= !flags[1];
        chr_ram  <= flags[0];
        @(negedge m2);
        check_chr_addr({name, "/chr_addr"}, {bank, addr[11:0]}, chr_addr);
        check_strobe({name, "/chr_ce"}, !addr[13], chr_ce);
        check_strobe({name, "/ciram_ce"}, !addr[13], ciram_ce);
        check_strobe({name, "/chr_oe"}, !flags[1], chr_oe);
        check_strobe({name, "/chr_we"}, flags[0] && flags[1], chr_we);
        check_strobe({name, "/ciram_a10"}, exp_a10, ciram_a10);
    endtask

    task automatic sst_write(input logic [2:0] slot, input logic [7:0] data);
        @(posedge m2);
        idle_bus();
        sst_enable  <= 1'b1;
        sst_we      <= 1'b1;
        sst_addr    <= slot;
        sst_data_in <= data;
    endtask

    task automatic sst_read(input string name, input logic [2:0] slot,
                            input mmc1_pkg::sst_byte_t exp);
        @(posedge m2);
        idle_bus();
        sst_addr <= slot;
        @(negedge m2);
        check_sst({name, "/sst_data_out"}, exp, sst_data_out);
    endtask

    task automatic load_vectors();
        int          fd;
        int          got;
        string       line;
        string       name;
        string       op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] d;
        fd = $fopen("tests/mmc1_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/mmc1_vectors.txt");
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got = $fgets(line, fd);
                if (got > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%s %s %h %h %h %h", name, op, a, b, c, d);
                    if (got != 6) begin
                        $display("Malformed vector line: %s", line);
                        abort_run();
                    end else begin
                        names.push_back(name);
                        ops.push_back(op);
                        f0s.push_back(a);
                        f1s.push_back(b);
                        f2s.push_back(c);
                        f3s.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ******************************
    // Main sequence
    // ******************************

    initial begin
        rst = 1'b1;
        cpu_addr = 16'h0000;
        cpu_rw = 1'b1;
        cpu_data_in = 8'h00;
        ppu_addr = 14'h0000;
        ppu_rd = 1'b1;
        ppu_wr = 1'b1;
        chr_ram = 1'b0;
        sst_enable = 1'b0;
        sst_we = 1'b0;
        sst_addr = 3'd0;
        sst_data_in = 8'h00;
        lfsr = 32'h102b_7710;
        cycles = 0;
        limit = 0;
        load_vectors();
        limit = 8 * names.size() + 50;
        repeat (5) @(posedge m2);
        rst <= 1'b0;
        for (int k = 0; k < names.size(); k++) begin
            case (ops[k])
                "cw": serial_write(f0s[k], f1s[k], f2s[k], f3s[k][0]);
                "cp": cpu_probe(names[k], f0s[k], f1s[k][0], f2s[k][4:0]);
                "pp": ppu_probe(names[k], f0s[k], f1s[k], f2s[k][4:0], f3s[k][1:0]);
                "sw": sst_write(f0s[k][2:0], f1s[k][7:0]);
                "sr": sst_read(names[k], f0s[k][2:0], f1s[k][7:0]);
                default: begin
                    $display("Unknown operation %s in vector %s", ops[k], names[k]);
                    abort_run();
                end
            endcase
        end
        @(posedge m2);
        $display("Everything OK");
        $finish;
    end

endmodule

/* compile.f */
+incdir+logic
logic/mmc1_pkg.sv
logic/mmc1_serial_loader.sv
logic/mmc1_bank_regs.sv
logic/mmc1_prg_window.sv
logic/mmc1_chr_window.sv
logic/mmc1_mapper.sv
tests/mmc1_mapper_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the MMC1 mapper testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module mmc1_mapper_tb \
    -Mdir obj_dir -o mmc1_sim
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

./obj_dir/mmc1_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q "Everything OK" sim.log; then
    exit 0
fi
echo "run.sh: pass message not found in sim.log"
exit 1

/* tests/mmc1_vectors.txt */
# name op f0 f1 f2 f3, fields in hex. cw: addr data count sst_en. cp: base rw bank -.
# pp: base flags(bit0 chr_ram, bit1 write) bank mirroring. sw: slot data - -. sr: slot expected - -.
rst_lo cp 8000 1 00 0
rst_hi cp c000 1 0f 0
rst_chr pp 1000 0 01 0
rst_shift sr 0 10 0 0
rst_ctrl sr 1 0c 0 0
ld_prg cw e000 05 5 0
last_lo cp 8000 1 05 0
last_hi cp c000 1 0f 0
ld_first cw 8000 08 5 0
first_lo cp 8000 1 00 0
first_hi cp c000 1 05 0
ld_32k cw 8000 00 5 0
w32k_lo cp 8000 1 04 0
ld_chr_hi cw a000 10 5 0
w32k_hi cp c000 1 15 0
part cw 8000 01 2 0
part_shift sr 0 0c 0 0
clr cw 8000 80 1 0
clr_shift sr 0 10 0 0
clr_ctrl sr 1 0c 0 0
clr_map cp c000 1 1f 0
after_clr cw e000 03 5 0
after_map cp 8000 1 13 0
ld_chr0 cw a000 07 5 0
ld_chr1 cw c000 0a 5 0
chr8k_hi pp 1000 0 07 0
ld_4k cw 8000 1f 5 0
chr4k_lo pp 0000 0 07 3
chr4k_hi pp 1000 0 0a 3
ram_rd pp 1000 1 01 3
ram_wr pp 0000 3 00 3
rom_wr_chr pp 0000 2 07 3
wram_rd cp 6000 1 00 0
wram_wr cp 6000 0 00 0
rom_wr cp 8000 0 03 0
rom_clr cw 8000 80 1 0
ld_mir0 cw 8000 1c 5 0
mir0 pp 2000 0 07 0
ld_mir1 cw 8000 1d 5 0
mir1 pp 2000 0 07 1
ld_mir2 cw 8000 1e 5 0
mir2 pp 2000 0 07 2
sst_shift sw 0 05 0 0
sst_ctrl sw 1 03 0 0
sst_chr0 sw 2 0b 0 0
sst_chr1 sw 3 15 0 0
sst_prg sw 4 09 0 0
sst_map cp c000 1 09 0
sst_block cw e000 01 5 1
rd_shift sr 0 05 0 0
rd_ctrl sr 1 03 0 0
rd_chr0 sr 2 0b 0 0
rd_chr1 sr 3 15 0 0
rd_prg sr 4 09 0 0
rd_none5 sr 5 ff 0 0
rd_none7 sr 7 ff 0 0
